// File: logic/mini_pipe_cfg.svh
`ifndef MINI_PIPE_CFG_SVH
`define MINI_PIPE_CFG_SVH

// data path width in bits
`define MP_XLEN 32

// r0 of the architectural registers reads as zero
`define MP_NREGS 32
`define MP_REG_IDX_W 5

// raw immediate carried in the low bits of the instruction word
`define MP_IMM_W 16

// data memory depth in 32-bit words
`define MP_DMEM_WORDS 256

`endif

// File: logic/mini_pipe_pkg.sv
`default_nettype none

`include "mini_pipe_cfg.svh"

package mini_pipe_pkg;

    localparam int INSTR_W = 32;

    // the immediate shares its bits with rs2 and the spare field of the instruction word
    localparam int OP_W = 5;
    localparam int OP_LO = 27;
    localparam int YSEL_BIT = 26;
    localparam int RD_LO = 21;
    localparam int RS1_LO = 16;
    localparam int RS2_LO = 11;
    localparam int IMM_LO = 0;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLT = 4'd5,
        OP_LW  = 4'd6,
        OP_LB  = 4'd7,
        OP_SW  = 4'd8
    } op_e;

    // memory and writeback controls that travel with the instruction
    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic byte_sel;
        logic reg_write;
    } ctrl_t;

    typedef struct packed {
        op_e                      op;
        logic [`MP_XLEN-1:0]      rs1_data;
        logic [`MP_XLEN-1:0]      rs2_data;
        logic [`MP_XLEN-1:0]      imm;
        logic                     y_sel;
        logic [`MP_REG_IDX_W-1:0] rd;
        ctrl_t                    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [`MP_REG_IDX_W-1:0] rd;
        logic                     reg_write;
        logic [`MP_XLEN-1:0]      data;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: logic/pipe_if.sv
`timescale 1ns/100ps
`default_nettype none

// a transfer happens on a clock edge where valid and ready are both high
interface pipe_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`MP_REG_IDX_W-1:0] rs1_idx,
    input  logic [`MP_REG_IDX_W-1:0] rs2_idx,
    output logic [`MP_XLEN-1:0]      rs1_data,
    output logic [`MP_XLEN-1:0]      rs2_data,
    input  logic                     we,
    input  logic [`MP_REG_IDX_W-1:0] wr_idx,
    input  logic [`MP_XLEN-1:0]      wr_data
);

    logic [`MP_XLEN-1:0] regs [`MP_NREGS];

    // reads are combinational so decode sees the value in the same cycle
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MP_NREGS; i++)
                regs[i] <= '0;
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module instr_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [mini_pipe_pkg::INSTR_W-1:0]   instr,
    output logic                                instr_ready,
    output logic [`MP_REG_IDX_W-1:0]            rs1_idx,
    output logic [`MP_REG_IDX_W-1:0]            rs2_idx,
    input  logic [`MP_XLEN-1:0]                 rs1_data,
    input  logic [`MP_XLEN-1:0]                 rs2_data,
    input  logic                                retire,
    input  logic [`MP_REG_IDX_W-1:0]            retire_rd,
    pipe_if.source                              out
);

    logic [mini_pipe_pkg::OP_W-1:0] op_field;
    logic                           op_known;
    mini_pipe_pkg::op_e             op;
    mini_pipe_pkg::ctrl_t           ctrl;
    logic [`MP_REG_IDX_W-1:0]       rd;
    logic                           y_sel;
    logic [`MP_IMM_W-1:0]           imm_raw;
    logic                           uses_rs2;
    logic                           hazard;
    logic                           accept;
    logic [`MP_NREGS-1:0]           pending_q;
    mini_pipe_pkg::id_ex_t          pkt;

    assign op_field = instr[mini_pipe_pkg::OP_LO +: mini_pipe_pkg::OP_W];
    assign y_sel    = instr[mini_pipe_pkg::YSEL_BIT];
    assign rd       = instr[mini_pipe_pkg::RD_LO +: `MP_REG_IDX_W];
    assign rs1_idx  = instr[mini_pipe_pkg::RS1_LO +: `MP_REG_IDX_W];
    assign rs2_idx  = instr[mini_pipe_pkg::RS2_LO +: `MP_REG_IDX_W];
    assign imm_raw  = instr[mini_pipe_pkg::IMM_LO +: `MP_IMM_W];

    // unknown opcodes become an ADD that writes nothing
    assign op_known = op_field <= mini_pipe_pkg::OP_W'(mini_pipe_pkg::OP_SW);
    assign op = op_known ? mini_pipe_pkg::op_e'(op_field[3:0]) : mini_pipe_pkg::OP_ADD;

    always_comb begin
        ctrl = '0;
        case (op)
            mini_pipe_pkg::OP_LW: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mini_pipe_pkg::OP_LB: begin
                ctrl.mem_read  = 1'b1;
                ctrl.byte_sel  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mini_pipe_pkg::OP_SW: ctrl.mem_write = 1'b1;
            default: ctrl.reg_write = op_known;
        endcase
    end

    // stores always read rs2 as their data, whatever y_sel says
    assign uses_rs2 = !y_sel || ctrl.mem_write;

    // a pending rd is also a hazard so that an older write cannot clear a newer one
    assign hazard = pending_q[rs1_idx] ||
                    (uses_rs2 && pending_q[rs2_idx]) ||
                    (ctrl.reg_write && pending_q[rd]);

    always_comb begin
        pkt.op       = op;
        pkt.rs1_data = rs1_data;
        pkt.rs2_data = rs2_data;
        pkt.imm      = {{(`MP_XLEN-`MP_IMM_W){imm_raw[`MP_IMM_W-1]}}, imm_raw};
        pkt.y_sel    = y_sel;
        pkt.rd       = rd;
        pkt.ctrl     = ctrl;
    end

    assign out.payload = pkt;
    assign out.valid   = instr_valid && !hazard;
    assign instr_ready = out.ready && !hazard;
    assign accept      = instr_valid && instr_ready;

    // r0 never gets a pending bit since it is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            if (retire)
                pending_q[retire_rd] <= 1'b0;
            if (accept && ctrl.reg_write && rd != '0)
                pending_q[rd] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic   clk,
    input  logic   rst_n,
    pipe_if.sink   in,
    pipe_if.source out
);

    logic     full_q;
    payload_t data_q;

    // the downstream ready acts as the stage enable, so the whole pipe
    // holds together while the result port is blocked
    assign in.ready    = out.ready;
    assign out.valid   = full_q;
    assign out.payload = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n)
            full_q <= 1'b0;
        else if (out.ready)
            full_q <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready)
            data_q <= in.payload;
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module exec_unit (
    input  logic   clk,
    input  logic   rst_n,
    pipe_if.sink   in,
    pipe_if.source out
);

    localparam int DMEM_AW = $clog2(`MP_DMEM_WORDS);

    logic [`MP_XLEN-1:0] dmem [`MP_DMEM_WORDS];
    logic [`MP_XLEN-1:0] op_a;
    logic [`MP_XLEN-1:0] op_b;
    logic [`MP_XLEN-1:0] alu_res;
    logic [`MP_XLEN-1:0] addr;
    logic [DMEM_AW-1:0]  word_idx;
    logic [`MP_XLEN-1:0] mem_word;
    logic [7:0]          mem_byte;
    logic [`MP_XLEN-1:0] load_val;
    logic                store;
    mini_pipe_pkg::ex_wb_t res;

    assign op_a = in.payload.rs1_data;
    assign op_b = in.payload.y_sel ? in.payload.imm : in.payload.rs2_data;

    always_comb begin
        case (in.payload.op)
            mini_pipe_pkg::OP_SUB: alu_res = op_a - op_b;
            mini_pipe_pkg::OP_AND: alu_res = op_a & op_b;
            mini_pipe_pkg::OP_OR:  alu_res = op_a | op_b;
            mini_pipe_pkg::OP_XOR: alu_res = op_a ^ op_b;
            mini_pipe_pkg::OP_SLT: begin
                alu_res = {{(`MP_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            default: alu_res = op_a + op_b;
        endcase
    end

    // the word address ignores the low two bits and LB picks the byte little-endian
    assign addr     = op_a + in.payload.imm;
    assign word_idx = addr[2 +: DMEM_AW];
    assign mem_word = dmem[word_idx];
    assign mem_byte = mem_word[{addr[1:0], 3'b000} +: 8];
    assign load_val = in.payload.ctrl.byte_sel ?
                      {{(`MP_XLEN-8){mem_byte[7]}}, mem_byte} : mem_word;

    assign store = in.valid && in.ready && in.payload.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MP_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (store) begin
            dmem[word_idx] <= in.payload.rs2_data;
        end
    end

    always_comb begin
        res.rd        = in.payload.rd;
        res.reg_write = in.payload.ctrl.reg_write;
        res.data      = in.payload.ctrl.mem_read ? load_val : alu_res;
    end

    // stores and writes to r0 leave as bubbles
    assign out.valid   = in.valid && in.payload.ctrl.reg_write && in.payload.rd != '0;
    assign out.payload = res;
    assign in.ready    = out.ready;

endmodule

`default_nettype wire

// File: logic/mini_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module mini_pipe (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              instr_valid,
    output logic                              instr_ready,
    input  logic [mini_pipe_pkg::INSTR_W-1:0] instr,
    output logic                              result_valid,
    input  logic                              result_ready,
    output logic [`MP_REG_IDX_W-1:0]          result_rd,
    output logic [`MP_XLEN-1:0]               result_data
);

    logic [`MP_REG_IDX_W-1:0] rs1_idx;
    logic [`MP_REG_IDX_W-1:0] rs2_idx;
    logic [`MP_XLEN-1:0]      rs1_data;
    logic [`MP_XLEN-1:0]      rs2_data;
    logic                     wb_en;

    pipe_if #(.payload_t(mini_pipe_pkg::id_ex_t)) id_ex_in ();
    pipe_if #(.payload_t(mini_pipe_pkg::id_ex_t)) id_ex_out ();
    pipe_if #(.payload_t(mini_pipe_pkg::ex_wb_t)) ex_wb_in ();
    pipe_if #(.payload_t(mini_pipe_pkg::ex_wb_t)) ex_wb_out ();

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .retire      (wb_en),
        .retire_rd   (result_rd),
        .out         (id_ex_in)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_en && ex_wb_out.payload.reg_write),
        .wr_idx   (result_rd),
        .wr_data  (result_data)
    );

    pipe_reg #(.payload_t(mini_pipe_pkg::id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (id_ex_in),
        .out   (id_ex_out)
    );

    exec_unit u_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (id_ex_out),
        .out   (ex_wb_in)
    );

    pipe_reg #(.payload_t(mini_pipe_pkg::ex_wb_t)) u_ex_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (ex_wb_in),
        .out   (ex_wb_out)
    );

    assign result_valid    = ex_wb_out.valid;
    assign result_rd       = ex_wb_out.payload.rd;
    assign result_data     = ex_wb_out.payload.data;
    assign ex_wb_out.ready = result_ready;

    // a result is written back and retired on the edge it leaves the port
    assign wb_en = result_valid && result_ready;

endmodule

`default_nettype wire

// File: tests/mini_pipe_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module mini_pipe_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     instr_ready,
    input logic                     result_valid,
    input logic                     result_ready,
    input logic [`MP_REG_IDX_W-1:0] result_rd,
    input logic [`MP_XLEN-1:0]      result_data
);

    int fail_count = 0;

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !result_valid)
        else begin
            $error("result_valid high in the first cycle after reset");
            fail_count++;
        end

    // a blocked result must sit unchanged on the port
    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !result_ready) |=>
            (result_valid && $stable(result_rd) && $stable(result_data)))
        else begin
            $error("result port changed while blocked");
            fail_count++;
        end

    no_r0_result: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> result_rd != '0)
        else begin
            $error("result presented for register zero");
            fail_count++;
        end

    stall_reaches_input: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !result_ready) |-> !instr_ready)
        else begin
            $error("instruction accepted while the result port is blocked");
            fail_count++;
        end

endmodule

bind mini_pipe mini_pipe_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_ready  (instr_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_rd    (result_rd),
    .result_data  (result_data)
);

`default_nettype wire

// File: tests/mini_pipe_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module mini_pipe_checker #(
    parameter int NAME_W = 128
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     result_valid,
    input  logic                     result_ready,
    input  logic [`MP_REG_IDX_W-1:0] result_rd,
    input  logic [`MP_XLEN-1:0]      result_data,
    input  logic                     exp_valid,
    input  logic [NAME_W-1:0]        exp_name,
    input  logic [`MP_REG_IDX_W-1:0] exp_rd,
    input  logic [`MP_XLEN-1:0]      exp_data,
    output int                       error_count,
    output int                       checked_count,
    output int                       pending_count
);

    logic [NAME_W-1:0]        name_q [$];
    logic [`MP_REG_IDX_W-1:0] rd_q [$];
    logic [`MP_XLEN-1:0]      data_q [$];
    int                       errors = 0;
    int                       checked = 0;
    int                       pending = 0;

    assign error_count   = errors;
    assign checked_count = checked;
    assign pending_count = pending;

    task automatic compare_result();
        logic [NAME_W-1:0]        name;
        logic [`MP_REG_IDX_W-1:0] rd;
        logic [`MP_XLEN-1:0]      data;
        if (name_q.size() == 0) begin
            $display("unexpected result on rd %0d with data %h while nothing was outstanding",
                     result_rd, result_data);
            errors++;
        end else begin
            name = name_q.pop_front();
            rd   = rd_q.pop_front();
            data = data_q.pop_front();
            checked++;
            if (result_rd !== rd || result_data !== data) begin
                $display("** Error %0s: expected rd=%0d data=%h, actual rd=%0d data=%h",
                         name, rd, data, result_rd, result_data);
                errors++;
            end
        end
    endtask

    // older results leave before the newest expectation is queued
    always @(posedge clk) begin
        if (rst_n && result_valid && result_ready)
            compare_result();
        if (rst_n && exp_valid) begin
            name_q.push_back(exp_name);
            rd_q.push_back(exp_rd);
            data_q.push_back(exp_data);
        end
        pending = name_q.size();
    end

endmodule

`default_nettype wire

// File: tests/mini_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mini_pipe_cfg.svh"

module mini_pipe_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

module mini_pipe_tb;

    localparam int NAME_W         = 128;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int QUIET_CYCLES   = 10;
    // the immediate setup rows run with the result port always ready
    localparam int STEADY_ROWS    = 5;

    logic                     clk;
    logic                     rst_n;
    logic                     instr_valid;
    logic                     instr_ready;
    logic [31:0]              instr;
    logic                     result_valid;
    logic                     result_ready;
    logic [`MP_REG_IDX_W-1:0] result_rd;
    logic [`MP_XLEN-1:0]      result_data;
    logic                     exp_valid;
    logic [NAME_W-1:0]        exp_name;
    logic [`MP_REG_IDX_W-1:0] exp_rd;
    logic [`MP_XLEN-1:0]      exp_data;
    logic                     hold_ready;
    int                       error_count;
    int                       checked_count;
    int                       pending_count;
    int                       tb_errors;
    integer                   seed;
    bit                       run_ok;

    logic [NAME_W-1:0]        row_name [$];
    logic [31:0]              row_word [$];
    bit                       row_res [$];
    logic [`MP_REG_IDX_W-1:0] row_rd [$];
    logic [`MP_XLEN-1:0]      row_data [$];

    mini_pipe_clk_gen #(.PERIOD_NS(20)) u_clk (.clk(clk));

    mini_pipe dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    mini_pipe_checker #(.NAME_W(NAME_W)) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result_rd     (result_rd),
        .result_data   (result_data),
        .exp_valid     (exp_valid),
        .exp_name      (exp_name),
        .exp_rd        (exp_rd),
        .exp_data      (exp_data),
        .error_count   (error_count),
        .checked_count (checked_count),
        .pending_count (pending_count)
    );

    function automatic logic [31:0] i_form(mini_pipe_pkg::op_e op, int rd, int rs1,
                                           logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[mini_pipe_pkg::OP_LO +: mini_pipe_pkg::OP_W] = mini_pipe_pkg::OP_W'(op);
        w[mini_pipe_pkg::YSEL_BIT] = 1'b1;
        w[mini_pipe_pkg::RD_LO +: `MP_REG_IDX_W] = `MP_REG_IDX_W'(rd);
        w[mini_pipe_pkg::RS1_LO +: `MP_REG_IDX_W] = `MP_REG_IDX_W'(rs1);
        w[mini_pipe_pkg::IMM_LO +: `MP_IMM_W] = imm;
        return w;
    endfunction

    function automatic logic [31:0] r_form(mini_pipe_pkg::op_e op, int rd, int rs1, int rs2);
        logic [31:0] w;
        w = i_form(op, rd, rs1, 16'h0000);
        w[mini_pipe_pkg::YSEL_BIT] = 1'b0;
        w[mini_pipe_pkg::RS2_LO +: `MP_REG_IDX_W] = `MP_REG_IDX_W'(rs2);
        return w;
    endfunction

    // rs2 fills the upper immediate bits, which lie above the bits that form the word index
    function automatic logic [31:0] sw_form(int rs1, int rs2, logic [10:0] off);
        logic [31:0] w;
        w = i_form(mini_pipe_pkg::OP_SW, 0, rs1, {5'b0, off});
        w[mini_pipe_pkg::RS2_LO +: `MP_REG_IDX_W] = `MP_REG_IDX_W'(rs2);
        return w;
    endfunction

    task automatic add_row(logic [NAME_W-1:0] name, logic [31:0] word, bit res, int rd,
                           logic [31:0] data);
        row_name.push_back(name);
        row_word.push_back(word);
        row_res.push_back(res);
        row_rd.push_back(`MP_REG_IDX_W'(rd));
        row_data.push_back(data);
    endtask

    task automatic build_table();
        add_row("addi r1", i_form(mini_pipe_pkg::OP_ADD, 1, 0, 16'h0005), 1, 1, 32'h0000_0005);
        add_row("addi r2", i_form(mini_pipe_pkg::OP_ADD, 2, 0, 16'hfffd), 1, 2, 32'hffff_fffd);
        add_row("ori r3", i_form(mini_pipe_pkg::OP_OR, 3, 0, 16'h00f0), 1, 3, 32'h0000_00f0);
        add_row("andi r4", i_form(mini_pipe_pkg::OP_AND, 4, 2, 16'h0ff0), 1, 4, 32'h0000_0ff0);
        add_row("xori r5", i_form(mini_pipe_pkg::OP_XOR, 5, 3, 16'hffff), 1, 5, 32'hffff_ff0f);
        add_row("add r7", r_form(mini_pipe_pkg::OP_ADD, 7, 1, 3), 1, 7, 32'h0000_00f5);
        add_row("sub r8 wrap", r_form(mini_pipe_pkg::OP_SUB, 8, 1, 3), 1, 8, 32'hffff_ff15);
        add_row("and r10", r_form(mini_pipe_pkg::OP_AND, 10, 5, 4), 1, 10, 32'h0000_0f00);
        add_row("or r11", r_form(mini_pipe_pkg::OP_OR, 11, 3, 1), 1, 11, 32'h0000_00f5);
        add_row("xor r12", r_form(mini_pipe_pkg::OP_XOR, 12, 5, 2), 1, 12, 32'h0000_00f2);
        add_row("slt neg", r_form(mini_pipe_pkg::OP_SLT, 13, 2, 1), 1, 13, 32'h0000_0001);
        add_row("slt pos", r_form(mini_pipe_pkg::OP_SLT, 14, 1, 2), 1, 14, 32'h0000_0000);
        // back-to-back chain through r16 and r17
        add_row("chain add", r_form(mini_pipe_pkg::OP_ADD, 16, 1, 1), 1, 16, 32'h0000_000a);
        add_row("chain sub", r_form(mini_pipe_pkg::OP_SUB, 16, 16, 2), 1, 16, 32'h0000_000d);
        add_row("chain dbl", r_form(mini_pipe_pkg::OP_ADD, 17, 16, 16), 1, 17, 32'h0000_001a);
        add_row("base r20", i_form(mini_pipe_pkg::OP_ADD, 20, 0, 16'h0040), 1, 20, 32'h0000_0040);
        add_row("data r21", i_form(mini_pipe_pkg::OP_ADD, 21, 0, 16'h8512), 1, 21, 32'hffff_8512);
        add_row("sw r21", sw_form(20, 21, 11'd0), 0, 0, 32'h0);
        add_row("sw r5", sw_form(20, 5, 11'd4), 0, 0, 32'h0);
        add_row("lw word", i_form(mini_pipe_pkg::OP_LW, 23, 20, 16'h0000), 1, 23, 32'hffff_8512);
        add_row("lb byte1", i_form(mini_pipe_pkg::OP_LB, 24, 20, 16'h0001), 1, 24, 32'hffff_ff85);
        add_row("lb byte0", i_form(mini_pipe_pkg::OP_LB, 25, 20, 16'h0000), 1, 25, 32'h0000_0012);
        add_row("lb byte4", i_form(mini_pipe_pkg::OP_LB, 26, 20, 16'h0004), 1, 26, 32'h0000_000f);
        add_row("lw unalign", i_form(mini_pipe_pkg::OP_LW, 27, 20, 16'h0006), 1, 27, 32'hffff_ff0f);
        add_row("addi r0", i_form(mini_pipe_pkg::OP_ADD, 0, 1, 16'h0007), 0, 0, 32'h0);
        add_row("read r0", r_form(mini_pipe_pkg::OP_ADD, 28, 0, 1), 1, 28, 32'h0000_0005);
    endtask

    task automatic post_expected(int idx);
        exp_valid = 1'b0;
        if (idx >= 0 && row_res[idx]) begin
            exp_valid = 1'b1;
            exp_name  = row_name[idx];
            exp_rd    = row_rd[idx];
            exp_data  = row_data[idx];
        end
    endtask

    // each expectation is posted as a one-cycle pulse after its row is accepted
    task automatic run_table(output bit ok);
        int  i;
        int  prev;
        int  waited;
        bit  accepted;
        ok   = 1'b1;
        prev = -1;
        i    = 0;
        hold_ready = 1'b1;
        while (ok && i < row_word.size()) begin
            @(negedge clk);
            post_expected(prev);
            instr       = row_word[i];
            instr_valid = 1'b1;
            waited      = 0;
            accepted    = 1'b0;
            while (ok && !accepted) begin
                @(posedge clk);
                if (instr_ready) begin
                    accepted = 1'b1;
                end else begin
                    waited++;
                    if (waited >= ACCEPT_TIMEOUT) begin
                        $display("instruction not accepted: %0s waited %0d cycles",
                                 row_name[i], waited);
                        tb_errors++;
                        ok = 1'b0;
                    end else begin
                        @(negedge clk);
                        exp_valid = 1'b0;
                    end
                end
            end
            hold_ready = (i + 1 < STEADY_ROWS);
            prev = i;
            i++;
        end
        @(negedge clk);
        instr_valid = 1'b0;
        if (ok)
            post_expected(prev);
        @(negedge clk);
        exp_valid = 1'b0;
    endtask

    task automatic wait_drain(output bit ok);
        int waited;
        ok     = 1'b1;
        waited = 0;
        while (ok && pending_count != 0) begin
            @(negedge clk);
            waited++;
            if (waited >= DRAIN_TIMEOUT && pending_count != 0) begin
                $display("results missing: %0d still outstanding after %0d cycles",
                         pending_count, waited);
                tb_errors++;
                ok = 1'b0;
            end
        end
        // a few more cycles let any extra result show up
        repeat (QUIET_CYCLES) @(negedge clk);
    endtask

    task automatic finish_run();
        int assert_fails;
        int total;
        assert_fails = dut0.u_assertions.fail_count;
        total = error_count + tb_errors + assert_fails;
        $display("checked %0d results, %0d mismatches, %0d assertion failures, %0d testbench errors",
                 checked_count, error_count, assert_fails, tb_errors);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    endtask

    always @(negedge clk) begin
        if (hold_ready)
            result_ready = 1'b1;
        else
            result_ready = (($random(seed) & 3) != 0);
    end

    initial begin
        seed         = 32'hbf0ea212;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b0;
        exp_valid    = 1'b0;
        exp_name     = '0;
        exp_rd       = '0;
        exp_data     = '0;
        hold_ready   = 1'b1;
        tb_errors    = 0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_table(run_ok);
        if (run_ok)
            wait_drain(run_ok);
        finish_run();
    end

endmodule

`default_nettype wire

// File: mini_pipe.f
+incdir+logic
logic/mini_pipe_pkg.sv
logic/pipe_if.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/pipe_reg.sv
logic/exec_unit.sv
logic/mini_pipe.sv
tests/mini_pipe_assertions.sv
tests/mini_pipe_checker.sv
tests/mini_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mini_pipe_tb \
    -f mini_pipe.f \
    --Mdir obj_dir

./obj_dir/Vmini_pipe_tb > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
